/* adc_types_pkg.sv */
// ====================
// adc types
// conversion word, per-channel sample and config fields
// ====================
`default_nettype none

package adc_types_pkg;

        localparam int NUM_CHANNELS = 4;

        // raw bytes as they arrive on the bus
        typedef struct packed {
                logic [7:0] hi_byte;
                logic [7:0] lo_byte;
        } adc_bytes_t;

        // decoded result, two leading zeros then id and code
        typedef struct packed {
                logic [1:0]  zero;
                logic [1:0]  ch_id;
                logic [11:0] code;
        } adc_result_t;

        typedef union packed {
                adc_bytes_t  bytes;
                adc_result_t result;
        } adc_word_t;

        typedef struct packed {
                logic [11:0] code;
                logic [11:0] mv;
        } adc_sample_t;

        // period in clock cycles
        typedef struct packed {
                logic [23:0] sample_period;
                logic [3:0]  chan_mask;
        } adc_cfg_t;

endpackage

`default_nettype wire

/* i2c_types_pkg.sv */
// ====================
// i2c types
// byte master operations and command word
// ====================
`default_nettype none

package i2c_types_pkg;

        typedef enum logic [1:0] {
                op_start,
                op_stop,
                op_write,
                op_read
        } i2c_op_t;

        // nack_last only matters on reads
        typedef struct packed {
                i2c_op_t    op;
                logic [7:0] data;
                logic       nack_last;
        } i2c_cmd_t;

endpackage

`default_nettype wire

/* i2c_byte_master.sv */
// ====================
// i2c byte master
// start, stop, byte write and byte read on open-drain lines,
// four timer ticks per scl period, no clock stretching
// ====================
`timescale 1ns/100ps
`default_nettype none

module i2c_byte_master #(
        parameter int CLK_DIV = 4
) (
        input  wire                     clk,
        input  wire                     rst,
        input  wire i2c_types_pkg::i2c_cmd_t cmd,
        input  wire                     cmd_go,
        output logic                    cmd_done,
        output logic [7:0]              rd_byte,
        output logic                    ack_ok,
        output logic                    scl_low,
        output logic                    sda_low,
        input  wire                     sda_in
);
        import i2c_types_pkg::*;

        logic        busy;
        i2c_cmd_t    cur;
        logic [15:0] div_cnt;
        logic [1:0]  qtr;
        logic [3:0]  bit_idx;
        logic [7:0]  shift;
        logic        tick;
        logic        byte_op;
        logic        last_qtr;
        logic        sda_first;

        assign tick     = busy && (div_cnt == 16'(CLK_DIV - 1));
        assign byte_op  = (cur.op == op_write) || (cur.op == op_read);
        // start and stop are one scl period, bytes are nine
        assign last_qtr = (qtr == 2'd3) && (!byte_op || bit_idx == 4'd8);
        assign rd_byte  = shift;

        // sda level set in the first quarter while scl is low
        always_comb begin
                case (cur.op)
                op_start: sda_first = 1'b0;
                op_stop:  sda_first = 1'b1;
                op_write: sda_first = (bit_idx < 4'd8) ? ~shift[7] : 1'b0;
                default:  sda_first = (bit_idx < 4'd8) ? 1'b0 : ~cur.nack_last;
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        busy     <= 1'b0;
                        div_cnt  <= '0;
                        qtr      <= '0;
                        bit_idx  <= '0;
                        cmd_done <= 1'b0;
                        ack_ok   <= 1'b0;
                        scl_low  <= 1'b0;
                        sda_low  <= 1'b0;
                end else begin
                        cmd_done <= 1'b0;
                        if (cmd_go && !busy) begin
                                busy    <= 1'b1;
                                div_cnt <= '0;
                                qtr     <= '0;
                                bit_idx <= '0;
                                ack_ok  <= 1'b1;
                        end else if (busy) begin
                                div_cnt <= tick ? '0 : div_cnt + 16'd1;
                        end

                        if (tick) begin
                                qtr <= qtr + 2'd1;
                                if (qtr == 2'd3)
                                        bit_idx <= bit_idx + 4'd1;
                                if (last_qtr) begin
                                        busy     <= 1'b0;
                                        cmd_done <= 1'b1;
                                end

                                case (qtr)
                                2'd0: sda_low <= sda_first;
                                2'd1: scl_low <= 1'b0;
                                2'd2: begin
                                        // start and stop edges while scl is high
                                        if (cur.op == op_start)
                                                sda_low <= 1'b1;
                                        else if (cur.op == op_stop)
                                                sda_low <= 1'b0;
                                        if (cur.op == op_write && bit_idx == 4'd8)
                                                ack_ok <= ~sda_in;
                                end
                                default: begin
                                        // leave scl released after stop
                                        if (cur.op != op_stop)
                                                scl_low <= 1'b1;
                                end
                                endcase
                        end
                end
        end

        // command and shift register
        always_ff @(posedge clk) begin
                if (cmd_go && !busy) begin
                        cur   <= cmd;
                        shift <= cmd.data;
                end else if (tick && bit_idx < 4'd8) begin
                        if (cur.op == op_write && qtr == 2'd3)
                                shift <= {shift[6:0], 1'b0};
                        if (cur.op == op_read && qtr == 2'd2)
                                shift <= {shift[6:0], sda_in};
                end
        end

        // sequencer waits for cmd_done before the next command
        go_when_idle: assert property (@(posedge clk) disable iff (rst)
                cmd_go |-> !busy);

        // data bits only move under scl low
        sda_in_low: assert property (@(posedge clk) disable iff (rst)
                $changed(sda_low) && byte_op |-> scl_low && $past(scl_low));

endmodule

`default_nettype wire

/* adc_sequencer.sv */
// ====================
// adc sequencer
// sweeps the enabled channels on a period timer, checks
// the channel id and scales each code to millivolts
// ====================
`timescale 1ns/100ps
`default_nettype none

module adc_sequencer #(
        parameter logic [6:0] DEV_ADDR = 7'h28,
        parameter int         VREF_MV  = 3300
) (
        input  wire                          clk,
        input  wire                          rst,
        input  wire adc_types_pkg::adc_cfg_t cfg,
        output i2c_types_pkg::i2c_cmd_t      cmd,
        output logic                         cmd_go,
        input  wire                          cmd_done,
        input  wire [7:0]                    rd_byte,
        input  wire                          ack_ok,
        output adc_types_pkg::adc_sample_t [adc_types_pkg::NUM_CHANNELS-1:0] samples,
        output logic                         sweep_done,
        output logic                         bus_error
);
        import adc_types_pkg::*;
        import i2c_types_pkg::*;

        localparam int CH_W = $clog2(NUM_CHANNELS);

        typedef enum logic {
                st_idle,
                st_busy
        } state_t;

        state_t                  state;
        logic [23:0]             period_cnt;
        logic [NUM_CHANNELS-1:0] mask_q;
        logic [NUM_CHANNELS-1:0] pending;
        logic [NUM_CHANNELS-1:0] rest;
        logic [CH_W-1:0]         chan;
        logic [3:0]              step;
        logic                    acks;
        logic [7:0]              hi_q;
        adc_word_t               word;
        logic [31:0]             mv_full;
        logic                    id_ok;

        // lowest pending channel goes first
        always_comb begin
                chan = '0;
                for (int i = NUM_CHANNELS - 1; i >= 0; i--) begin
                        if (pending[i])
                                chan = CH_W'(i);
                end
                rest       = pending;
                rest[chan] = 1'b0;
        end

        always_comb begin
                word.bytes.hi_byte = hi_q;
                word.bytes.lo_byte = rd_byte;
        end

        assign id_ok   = acks && (word.result.ch_id == chan);
        assign mv_full = 32'(word.result.code) * 32'(VREF_MV);

        // per channel: config write then two-byte read
        always_comb begin
                cmd.op        = op_stop;
                cmd.data      = 8'h00;
                cmd.nack_last = 1'b0;
                case (step)
                4'd0, 4'd4: cmd.op = op_start;
                4'd1: begin
                        cmd.op   = op_write;
                        cmd.data = {DEV_ADDR, 1'b0};
                end
                4'd2: begin
                        cmd.op   = op_write;
                        cmd.data = 8'h10 << chan;
                end
                4'd5: begin
                        cmd.op   = op_write;
                        cmd.data = {DEV_ADDR, 1'b1};
                end
                4'd6: cmd.op = op_read;
                4'd7: begin
                        cmd.op        = op_read;
                        cmd.nack_last = 1'b1;
                end
                default: cmd.op = op_stop;
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state      <= st_idle;
                        period_cnt <= '0;
                        mask_q     <= '0;
                        pending    <= '0;
                        step       <= '0;
                        acks       <= 1'b0;
                        cmd_go     <= 1'b0;
                        sweep_done <= 1'b0;
                        bus_error  <= 1'b0;
                        samples    <= '0;
                end else begin
                        cmd_go     <= 1'b0;
                        sweep_done <= 1'b0;
                        bus_error  <= 1'b0;
                        if (state == st_idle) begin
                                if (period_cnt == cfg.sample_period) begin
                                        period_cnt <= '0;
                                        // empty mask just restarts the count
                                        if (cfg.chan_mask != '0) begin
                                                mask_q  <= cfg.chan_mask;
                                                pending <= cfg.chan_mask;
                                                step    <= '0;
                                                acks    <= 1'b1;
                                                cmd_go  <= 1'b1;
                                                state   <= st_busy;
                                        end
                                end else begin
                                        period_cnt <= period_cnt + 24'd1;
                                end
                        end else if (cmd_done) begin
                                cmd_go <= 1'b1;
                                step   <= step + 4'd1;
                                if (step == 4'd1 || step == 4'd2 || step == 4'd5)
                                        acks <= acks & ack_ok;
                                if (step == 4'd7) begin
                                        if (id_ok)
                                                samples[chan] <= '{code: word.result.code,
                                                                   mv:   mv_full[23:12]};
                                        else
                                                bus_error <= 1'b1;
                                end
                                if (step == 4'd8) begin
                                        pending <= rest;
                                        step    <= '0;
                                        acks    <= 1'b1;
                                        if (rest == '0) begin
                                                cmd_go     <= 1'b0;
                                                sweep_done <= 1'b1;
                                                state      <= st_idle;
                                        end
                                end
                        end
                end
        end

        // high byte held until the low byte arrives
        always_ff @(posedge clk) begin
                if (state == st_busy && cmd_done && step == 4'd6)
                        hi_q <= rd_byte;
        end

        chan_in_mask: assert property (@(posedge clk) disable iff (rst)
                state == st_busy |-> mask_q[chan] && (pending & ~mask_q) == '0);

endmodule

`default_nettype wire

/* adc_config_regs.sv */
// ====================
// adc config registers
// write-only sample period and channel mask
// ====================
`timescale 1ns/100ps
`default_nettype none

module adc_config_regs (
        input  wire                      clk,
        input  wire                      rst,
        input  wire                      cfg_we,
        input  wire                      cfg_addr,
        input  wire [31:0]               cfg_wdata,
        output adc_types_pkg::adc_cfg_t  cfg
);
        // shorter periods leave no idle gap between sweeps
        localparam logic [23:0] MIN_PERIOD = 24'd16;

        // address 0 period, address 1 mask
        always_ff @(posedge clk) begin
                if (rst) begin
                        cfg.sample_period <= 24'd1000;
                        cfg.chan_mask     <= 4'hf;
                end else if (cfg_we) begin
                        if (cfg_addr)
                                cfg.chan_mask <= cfg_wdata[3:0];
                        else
                                cfg.sample_period <= cfg_wdata[23:0];
                end
        end

        period_min: assert property (@(posedge clk) disable iff (rst)
                cfg_we && !cfg_addr |=> cfg.sample_period >= MIN_PERIOD);

endmodule

`default_nettype wire

/* pmod_adc_top.sv */
// ====================
// pmod adc top
// config block, sweep sequencer and i2c byte master
// ====================
`timescale 1ns/100ps
`default_nettype none

module pmod_adc_top #(
        parameter int         CLK_DIV  = 4,
        parameter logic [6:0] DEV_ADDR = 7'h28,
        parameter int         VREF_MV  = 3300
) (
        input  wire         clk,
        input  wire         rst,
        input  wire         cfg_we,
        input  wire         cfg_addr,
        input  wire [31:0]  cfg_wdata,
        output logic        scl_low,
        output logic        sda_low,
        input  wire         sda_in,
        output adc_types_pkg::adc_sample_t [adc_types_pkg::NUM_CHANNELS-1:0] samples,
        output logic        sweep_done,
        output logic        bus_error
);
        import adc_types_pkg::*;
        import i2c_types_pkg::*;

        adc_cfg_t   cfg;
        i2c_cmd_t   cmd;
        logic       cmd_go;
        logic       cmd_done;
        logic [7:0] rd_byte;
        logic       ack_ok;

        adc_config_regs u_config_regs (
                .clk       (clk),
                .rst       (rst),
                .cfg_we    (cfg_we),
                .cfg_addr  (cfg_addr),
                .cfg_wdata (cfg_wdata),
                .cfg       (cfg)
        );

        adc_sequencer #(
                .DEV_ADDR (DEV_ADDR),
                .VREF_MV  (VREF_MV)
        ) u_sequencer (
                .clk        (clk),
                .rst        (rst),
                .cfg        (cfg),
                .cmd        (cmd),
                .cmd_go     (cmd_go),
                .cmd_done   (cmd_done),
                .rd_byte    (rd_byte),
                .ack_ok     (ack_ok),
                .samples    (samples),
                .sweep_done (sweep_done),
                .bus_error  (bus_error)
        );

        i2c_byte_master #(
                .CLK_DIV (CLK_DIV)
        ) u_byte_master (
                .clk      (clk),
                .rst      (rst),
                .cmd      (cmd),
                .cmd_go   (cmd_go),
                .cmd_done (cmd_done),
                .rd_byte  (rd_byte),
                .ack_ok   (ack_ok),
                .scl_low  (scl_low),
                .sda_low  (sda_low),
                .sda_in   (sda_in)
        );

endmodule

`default_nettype wire

/* adc_i2c_model.sv */
// ====================
// adc i2c model
// slave model of the four-channel adc, settable codes,
// address nack and wrong id faults, config write counts
// ====================
`timescale 1ns/100ps
`default_nettype none

module adc_i2c_model #(
        parameter logic [6:0] DEV_ADDR = 7'h28
) (
        input  wire             clk,
        input  wire             rst,
        input  wire             scl,
        input  wire             sda,
        output logic            sda_pull,
        input  wire [3:0][11:0] codes,
        input  wire             nack_addr,
        input  wire [3:0]       bad_id,
        output logic [3:0][7:0] cfg_count
);
        import adc_types_pkg::*;

        logic       scl_q;
        logic       sda_q;
        logic [3:0] bit_cnt;
        logic [1:0] byte_idx;
        logic [7:0] rx;
        logic       addressed;
        logic       is_read;
        logic [1:0] chan;
        logic [1:0] cfg_chan;
        logic [7:0] cur_byte;
        logic [7:0] next_byte;
        adc_word_t  word;

        // lowest one-hot bit of the config nibble
        always_comb begin
                cfg_chan = 2'd0;
                for (int i = 3; i >= 0; i--) begin
                        if (rx[4 + i])
                                cfg_chan = 2'(i);
                end
        end

        // reply word, id skewed by one on a fault
        always_comb begin
                word.result.zero  = 2'b00;
                word.result.ch_id = bad_id[chan] ? chan + 2'd1 : chan;
                word.result.code  = codes[chan];
                cur_byte  = (byte_idx == 2'd1) ? word.bytes.hi_byte : word.bytes.lo_byte;
                next_byte = (byte_idx == 2'd0) ? word.bytes.hi_byte : word.bytes.lo_byte;
        end

        // lines sampled each clock, edges found against the last sample
        always_ff @(posedge clk) begin
                if (rst) begin
                        scl_q     <= 1'b1;
                        sda_q     <= 1'b1;
                        bit_cnt   <= '0;
                        byte_idx  <= '0;
                        rx        <= '0;
                        addressed <= 1'b0;
                        is_read   <= 1'b0;
                        chan      <= '0;
                        sda_pull  <= 1'b0;
                        cfg_count <= '0;
                end else begin
                        scl_q <= scl;
                        sda_q <= sda;
                        if (scl_q && scl && sda_q && !sda) begin
                                // start
                                bit_cnt   <= '0;
                                byte_idx  <= '0;
                                addressed <= 1'b0;
                                is_read   <= 1'b0;
                                sda_pull  <= 1'b0;
                        end else if (scl_q && scl && !sda_q && sda) begin
                                // stop
                                addressed <= 1'b0;
                                sda_pull  <= 1'b0;
                        end else if (!scl_q && scl) begin
                                bit_cnt <= bit_cnt + 4'd1;
                                if (bit_cnt < 4'd8)
                                        rx <= {rx[6:0], sda};
                        end else if (scl_q && !scl) begin
                                case (bit_cnt)
                                4'd8: begin
                                        sda_pull <= 1'b0;
                                        if (byte_idx == 2'd0) begin
                                                if (rx[7:1] == DEV_ADDR && !nack_addr) begin
                                                        addressed <= 1'b1;
                                                        is_read   <= rx[0];
                                                        sda_pull  <= 1'b1;
                                                end
                                        end else if (addressed && !is_read) begin
                                                chan                <= cfg_chan;
                                                cfg_count[cfg_chan] <= cfg_count[cfg_chan] + 8'd1;
                                                sda_pull            <= 1'b1;
                                        end
                                end
                                4'd9: begin
                                        bit_cnt  <= '0;
                                        byte_idx <= byte_idx + 2'd1;
                                        // first bit of the next read byte
                                        sda_pull <= addressed && is_read && byte_idx < 2'd2
                                                    && !next_byte[7];
                                end
                                default: begin
                                        if (addressed && is_read && byte_idx != 2'd0
                                            && bit_cnt != 4'd0)
                                                sda_pull <= !cur_byte[3'd7 - bit_cnt[2:0]];
                                end
                                endcase
                        end
                end
        end

endmodule

`default_nettype wire

/* tb_pmod_adc.sv */
// ====================
// pmod adc testbench
// sweeps with random codes, channel masks and bus faults
// against an i2c model of the adc
// ====================
`timescale 1ns/100ps
`default_nettype none

module tb_pmod_adc;
        import adc_types_pkg::*;

        localparam int         CLK_DIV       = 2;
        localparam logic [6:0] DEV_ADDR      = 7'h28;
        localparam int         VREF_MV       = 3300;
        localparam int         SWEEP_TIMEOUT = 20000;
        // bus time of a full sweep, five bytes of nine bits and four
        // start or stop per channel, four quarter ticks per scl period
        localparam int         MIN_SWEEP     = NUM_CHANNELS * (5 * 9 + 4) * 4 * CLK_DIV;

        logic                           clk;
        logic                           rst;
        logic                           cfg_we;
        logic                           cfg_addr;
        logic [31:0]                    cfg_wdata;
        logic                           scl_low;
        logic                           sda_low;
        wire                            sda_in;
        wire                            scl;
        logic                           model_pull;
        adc_sample_t [NUM_CHANNELS-1:0] samples;
        logic                           sweep_done;
        logic                           bus_error;
        logic [3:0][11:0]               codes;
        logic                           nack_addr;
        logic [3:0]                     bad_id;
        logic [3:0][7:0]                cfg_count;
        logic [3:0][7:0]                count_base;
        adc_sample_t                    exp_samples [NUM_CHANNELS];
        logic [31:0]                    lcg_state;
        int                             errors       = 0;
        int                             test_base    = 0;
        int                             err_pulses   = 0;
        int                             tests_run    = 0;
        int                             tests_failed = 0;

        // pull-ups, a line reads 1 unless someone pulls it low
        assign scl    = !(scl_low === 1'b1);
        assign sda_in = !(sda_low === 1'b1 || model_pull === 1'b1);

        pmod_adc_top #(
                .CLK_DIV  (CLK_DIV),
                .DEV_ADDR (DEV_ADDR),
                .VREF_MV  (VREF_MV)
        ) u_pmod_adc_top (
                .clk        (clk),
                .rst        (rst),
                .cfg_we     (cfg_we),
                .cfg_addr   (cfg_addr),
                .cfg_wdata  (cfg_wdata),
                .scl_low    (scl_low),
                .sda_low    (sda_low),
                .sda_in     (sda_in),
                .samples    (samples),
                .sweep_done (sweep_done),
                .bus_error  (bus_error)
        );

        adc_i2c_model #(
                .DEV_ADDR (DEV_ADDR)
        ) u_model (
                .clk       (clk),
                .rst       (rst),
                .scl       (scl),
                .sda       (sda_in),
                .sda_pull  (model_pull),
                .codes     (codes),
                .nack_addr (nack_addr),
                .bad_id    (bad_id),
                .cfg_count (cfg_count)
        );

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1103515245 + 32'd12345;
        endfunction

        // code times vref over full scale, truncated
        function automatic adc_sample_t expected_sample(input logic [11:0] code);
                adc_sample_t s;
                int          mv;
                mv     = (int'(code) * VREF_MV) / 4096;
                s.code = code;
                s.mv   = mv[11:0];
                return s;
        endfunction

        task automatic check_sample(input string name, input adc_sample_t got,
                                    input adc_sample_t exp);
                if (got !== exp) begin
                        $display("CHECK FAILED at %0t: %s got code %0d mv %0d, %s",
                                 $time, name, got.code, got.mv,
                                 $sformatf("expected code %0d mv %0d", exp.code, exp.mv));
                        errors++;
                end
        endtask

        task automatic check_bit(input string name, input logic got, input logic exp);
                if (got !== exp) begin
                        $display("CHECK FAILED at %0t: %s got %b, expected %b",
                                 $time, name, got, exp);
                        errors++;
                end
        endtask

        task automatic new_codes();
                for (int n = 0; n < NUM_CHANNELS; n++) begin
                        lcg_state = lcg_next(lcg_state);
                        codes[n]  = lcg_state[27:16];
                end
        endtask

        // enabled channels take the new codes, the rest hold
        task automatic set_expected(input logic [3:0] mask);
                for (int n = 0; n < NUM_CHANNELS; n++) begin
                        if (mask[n])
                                exp_samples[n] = expected_sample(codes[n]);
                end
        endtask

        task automatic write_cfg(input logic addr, input logic [31:0] data);
                cfg_we    = 1'b1;
                cfg_addr  = addr;
                cfg_wdata = data;
                @(posedge clk);
                #5;
                cfg_we = 1'b0;
        endtask

        // ends at the drive point after sweep_done
        task automatic wait_sweep(output int cycles);
                cycles = 0;
                do begin
                        @(negedge clk);
                        cycles++;
                end while (sweep_done !== 1'b1 && cycles < SWEEP_TIMEOUT);
                if (sweep_done !== 1'b1) begin
                        $display("timeout: no sweep_done within %0d cycles at %0t",
                                 SWEEP_TIMEOUT, $time);
                        errors++;
                end
                @(posedge clk);
                #5;
        endtask

        task automatic report_test(input string name);
                tests_run++;
                if (errors == test_base) begin
                        $display("test %0d %s: ok", tests_run, name);
                end else begin
                        tests_failed++;
                        $display("test %0d %s: FAILED with %0d errors", tests_run, name,
                                 errors - test_base);
                end
                test_base = errors;
        endtask

        // each finished sweep is compared against the expected samples
        always @(negedge clk) begin
                if (rst === 1'b0) begin
                        if (bus_error)
                                err_pulses++;
                        if (sweep_done) begin
                                for (int n = 0; n < NUM_CHANNELS; n++)
                                        check_sample($sformatf("samples[%0d]", n), samples[n],
                                                     exp_samples[n]);
                        end
                end
        end

        initial begin
                int cycles;
                int err_base;
                rst       = 1'b1;
                cfg_we    = 1'b0;
                cfg_addr  = 1'b0;
                cfg_wdata = '0;
                nack_addr = 1'b0;
                bad_id    = '0;
                lcg_state = 32'hbb00;
                new_codes();
                for (int n = 0; n < NUM_CHANNELS; n++)
                        exp_samples[n] = '0;
                repeat (5) @(posedge clk);
                #5;
                rst = 1'b0;

                // reset values, then the first sweep on the default period
                @(negedge clk);
                for (int n = 0; n < NUM_CHANNELS; n++)
                        check_sample($sformatf("samples[%0d]", n), samples[n], '0);
                check_bit("scl_low", scl_low, 1'b0);
                check_bit("sda_low", sda_low, 1'b0);
                check_bit("sweep_done", sweep_done, 1'b0);
                check_bit("bus_error", bus_error, 1'b0);
                set_expected(4'hf);
                wait_sweep(cycles);
                check_bit("sweep_done after sample_period", cycles >= 1000 + MIN_SWEEP, 1'b1);
                report_test("reset and first sweep");

                write_cfg(1'b0, 32'd200);
                new_codes();
                set_expected(4'hf);
                count_base = cfg_count;
                err_base   = err_pulses;
                wait_sweep(cycles);
                for (int n = 0; n < NUM_CHANNELS; n++)
                        check_bit($sformatf("config writes ch%0d", n),
                                  cfg_count[n] == count_base[n] + 8'd1, 1'b1);
                check_bit("bus_error seen", err_pulses != err_base, 1'b0);
                report_test("all channels random codes");

                write_cfg(1'b1, 32'h5);
                new_codes();
                set_expected(4'b0101);
                count_base = cfg_count;
                wait_sweep(cycles);
                for (int n = 0; n < NUM_CHANNELS; n++)
                        check_bit($sformatf("config writes ch%0d", n),
                                  cfg_count[n] == count_base[n] + 8'(n % 2 == 0), 1'b1);
                report_test("channel subset");

                // address nack on a single enabled channel, an idle bus
                // reads back as this channel's own id
                write_cfg(1'b1, 32'h8);
                nack_addr = 1'b1;
                new_codes();
                err_base = err_pulses;
                wait_sweep(cycles);
                check_bit("one bus_error pulse", (err_pulses - err_base) == 1, 1'b1);
                nack_addr = 1'b0;
                report_test("address nack");

                write_cfg(1'b1, 32'hf);
                bad_id = 4'b0100;
                new_codes();
                set_expected(4'b1011);
                err_base = err_pulses;
                wait_sweep(cycles);
                check_bit("one bus_error pulse", (err_pulses - err_base) == 1, 1'b1);
                bad_id = '0;
                report_test("wrong channel id");

                $display("tests run %0d, failed %0d, check errors %0d",
                         tests_run, tests_failed, errors);
                if (errors == 0)
                        $display("Regression passed");
                else
                        $display("Regression failed");
                $finish;
        end

endmodule

`default_nettype wire

/* verilog.f */
adc_types_pkg.sv
i2c_types_pkg.sv
i2c_byte_master.sv
adc_sequencer.sv
adc_config_regs.sv
pmod_adc_top.sv
adc_i2c_model.sv
tb_pmod_adc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the pmod adc testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps \
        --top-module tb_pmod_adc -f verilog.f -o sim_pmod_adc

./obj_dir/sim_pmod_adc | tee sim.log

if grep -q "Regression failed" sim.log; then
        exit 1
fi
